//--- tg_macros.svh
`ifndef TG_MACROS_SVH
`define TG_MACROS_SVH

// flow count and index width
`define TG_NUM_FLOWS 4
`define TG_FLOW_IDX_BITS 2

// stream beat geometry
`define TG_BEAT_BITS 512
`define TG_BEAT_BYTES 64

// header fields shared by every flow
`define TG_DST_MAC 48'h001112345678
`define TG_DST_IP 32'hC0A8640A
`define TG_DST_PORT 16'h1234
`define TG_PROTOCOL 8'h06
`define TG_ETHERTYPE 16'h0800
// marker that follows the timestamp
`define TG_TAIL_MARK 16'h1234

// payload filler and trailing crc word
`define TG_FILL_BYTE 8'h41
`define TG_CRC_WORD 32'h0a212121

`endif

//--- tg_pkg.sv
`default_nettype none

`include "tg_macros.svh"

package tg_pkg;

    // per-flow configuration, 144 bits
    typedef struct packed {
        logic [47:0] src_mac;
        logic [31:0] src_ip;
        logic [15:0] src_port;
        // packet length in bytes
        logic [15:0] pkt_size;
        // min spacing between first beats
        logic [31:0] cycles_per_pkt;
    } flow_cfg_t;

    typedef logic [`TG_FLOW_IDX_BITS-1:0] flow_idx_t;

    // flow phase
    typedef enum logic [1:0] {
        PH_IDLE     = 2'b00,
        PH_TRANSFER = 2'b01,
        PH_WAIT     = 2'b10
    } flow_phase_e;

    // header beat layout, msb first
    typedef struct packed {
        // dst mac, src mac, ethertype
        logic [111:0] eth;
        // zeros, protocol, zeros, src ip, dst ip
        logic [159:0] ip;
        // src port, dst port, zeros
        logic [159:0] trans;
        // timestamp, tail mark, zeros
        logic [79:0]  tail;
    } hdr_beat_t;

    // one beat seen as header fields or as raw bytes
    typedef union packed {
        hdr_beat_t hdr;
        logic [`TG_BEAT_BYTES-1:0][7:0] bytes;
    } beat_u;

endpackage

`default_nettype wire

//--- beat_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface beat_ctrl_if;

    // first beat of the packet
    logic        is_header;
    // last beat of the packet
    logic        crc_beat;
    // current flow addressing
    logic [47:0] src_mac;
    logic [31:0] src_ip;
    logic [15:0] src_port;

    // flow engine side
    modport source (
        output is_header, crc_beat, src_mac, src_ip, src_port
    );

    // beat composer side
    modport sink (
        input is_header, crc_beat, src_mac, src_ip, src_port
    );

endinterface

`default_nettype wire

//--- flow_scheduler.sv
`timescale 1ns/1ps
`default_nettype none

`include "tg_macros.svh"

module flow_scheduler (
    input  wire logic                     axi_aclk,
    input  wire logic                     aresetn,
    input  wire logic [`TG_NUM_FLOWS-1:0] flow_running,
    input  wire logic                     advance,
    output tg_pkg::flow_idx_t             cur_idx
);

    tg_pkg::flow_idx_t next_idx;

    // rotating search, starting just after the current flow
    always_comb begin
        logic              found;
        tg_pkg::flow_idx_t cand;
        found    = 1'b0;
        next_idx = cur_idx;
        for (int i = 1; i < `TG_NUM_FLOWS; i++) begin
            cand = tg_pkg::flow_idx_t'((int'(cur_idx) + i) % `TG_NUM_FLOWS);
            // first running hit wins
            if (!found && flow_running[cand]) begin
                next_idx = cand;
                found    = 1'b1;
            end
        end
        // no other runner, so next_idx stays on cur_idx
    end

    always_ff @(posedge axi_aclk) begin
        if (!aresetn) begin
            cur_idx <= '0;
        end else if (advance) begin
            cur_idx <= next_idx;
        end
    end

    // index only moves on the cycle after an advance pulse
    a_idx_hold : assert property (
        @(posedge axi_aclk) disable iff (!aresetn)
        !advance |=> $stable(cur_idx)
    );

endmodule

`default_nettype wire

//--- flow_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "tg_macros.svh"

module flow_engine (
    input  wire logic                     axi_aclk,
    input  wire logic                     aresetn,
    input  tg_pkg::flow_cfg_t             flow_cfg [`TG_NUM_FLOWS],
    input  wire logic [`TG_NUM_FLOWS-1:0] flow_running,
    input  tg_pkg::flow_idx_t             cur_idx,
    input  wire logic                     rx_ready,
    input  wire logic                     crdt_valid,
    input  wire logic                     qid_fifo_full,
    output logic                          rx_valid,
    output logic                          rx_last,
    output logic                          advance,
    beat_ctrl_if.source                   ctrl
);

    // per-flow state
    tg_pkg::flow_phase_e phase     [`TG_NUM_FLOWS];
    logic [15:0]         byte_cnt  [`TG_NUM_FLOWS];
    logic                hdr_flag  [`TG_NUM_FLOWS];
    logic [31:0]         wait_cnt  [`TG_NUM_FLOWS];

    // advance seen last cycle, keeps the pulse one cycle wide
    logic switch_q;

    tg_pkg::flow_cfg_t   cur_cfg;
    tg_pkg::flow_phase_e cur_phase;
    logic                cur_running;
    logic                gate_ok;
    logic                pace_done;
    logic                last_beat;
    logic                start;
    logic                accept;
    logic                done;

    assign cur_cfg     = flow_cfg[cur_idx];
    assign cur_phase   = phase[cur_idx];
    assign cur_running = flow_running[cur_idx];

    // start gate, levels only
    assign gate_ok = rx_ready && crdt_valid && !qid_fifo_full;
    // wait_cnt >= cycles_per_pkt - 1, kept in 33 bits so zero spacing works
    assign pace_done = ({1'b0, wait_cnt[cur_idx]} + 33'd1) >= {1'b0, cur_cfg.cycles_per_pkt};
    // remaining bytes fit in this beat
    assign last_beat = ({1'b0, byte_cnt[cur_idx]} + 17'(`TG_BEAT_BYTES))
                       >= {1'b0, cur_cfg.pkt_size};

    assign start = cur_running && gate_ok &&
                   ((cur_phase == tg_pkg::PH_IDLE) ||
                    (cur_phase == tg_pkg::PH_WAIT && pace_done));

    // valid held off right after a switch to a flow already mid-packet
    assign rx_valid = cur_running && (cur_phase == tg_pkg::PH_TRANSFER) && !switch_q;
    assign rx_last  = rx_valid && last_beat;
    assign accept   = rx_valid && rx_ready;
    assign done     = accept && last_beat;
    // move on after a packet, or skip a stopped flow
    assign advance  = !switch_q && (done || !cur_running);

    // beat control for the composer
    assign ctrl.is_header = hdr_flag[cur_idx];
    assign ctrl.crc_beat  = last_beat;
    assign ctrl.src_mac   = cur_cfg.src_mac;
    assign ctrl.src_ip    = cur_cfg.src_ip;
    assign ctrl.src_port  = cur_cfg.src_port;

    always_ff @(posedge axi_aclk) begin
        if (!aresetn) begin
            switch_q <= 1'b0;
            for (int i = 0; i < `TG_NUM_FLOWS; i++) begin
                phase[i]    <= tg_pkg::PH_IDLE;
                byte_cnt[i] <= '0;
                hdr_flag[i] <= 1'b1;
                wait_cnt[i] <= '0;
            end
        end else begin
            switch_q <= advance;
            for (int i = 0; i < `TG_NUM_FLOWS; i++) begin
                if (!flow_running[i] && phase[i] == tg_pkg::PH_WAIT) begin
                    // stopped while pacing, back to idle
                    phase[i]    <= tg_pkg::PH_IDLE;
                    byte_cnt[i] <= '0;
                    hdr_flag[i] <= 1'b1;
                    wait_cnt[i] <= '0;
                end else if (flow_running[i]) begin
                    // pacing counter, saturating
                    if (phase[i] == tg_pkg::PH_IDLE) begin
                        wait_cnt[i] <= '0;
                    end else if (wait_cnt[i] != '1) begin
                        wait_cnt[i] <= wait_cnt[i] + 32'd1;
                    end
                    if (i == int'(cur_idx)) begin
                        if (start) begin
                            phase[i]    <= tg_pkg::PH_TRANSFER;
                            // spacing measured from this first beat
                            wait_cnt[i] <= '0;
                        end else if (accept) begin
                            hdr_flag[i] <= 1'b0;
                            if (last_beat) begin
                                phase[i]    <= tg_pkg::PH_WAIT;
                                byte_cnt[i] <= '0;
                                hdr_flag[i] <= 1'b1;
                            end else begin
                                byte_cnt[i] <= byte_cnt[i] + 16'(`TG_BEAT_BYTES);
                            end
                        end
                    end
                end
            end
        end
    end

    // last beat is always a presented beat
    a_last_valid : assert property (
        @(posedge axi_aclk) disable iff (!aresetn)
        rx_last |-> rx_valid
    );

    // scheduler never sees back-to-back advance
    a_adv_pulse : assert property (
        @(posedge axi_aclk) disable iff (!aresetn)
        advance |=> !advance
    );

endmodule

`default_nettype wire

//--- beat_composer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tg_macros.svh"

module beat_composer (
    input  wire logic [31:0]             timestamp,
    beat_ctrl_if.sink                    ctrl,
    output logic [`TG_BEAT_BITS-1:0]     rx_data
);

    tg_pkg::beat_u beat;

    always_comb begin
        // payload default, every byte is filler
        beat.bytes = {`TG_BEAT_BYTES{`TG_FILL_BYTE}};

        // first beat carries the full header
        if (ctrl.is_header) begin
            beat.hdr.eth = {
                `TG_DST_MAC,
                ctrl.src_mac,
                `TG_ETHERTYPE
            };
            beat.hdr.ip = {
                72'h0,
                `TG_PROTOCOL,
                16'h0,
                ctrl.src_ip,
                `TG_DST_IP
            };
            beat.hdr.trans = {
                ctrl.src_port,
                `TG_DST_PORT,
                128'h0
            };
            // timestamp sampled as the beat is presented
            beat.hdr.tail = {
                timestamp,
                `TG_TAIL_MARK,
                32'h0
            };
        end

        // crc word on the low four bytes of the last beat
        // one-beat packets get it on top of the header
        if (ctrl.crc_beat) begin
            beat.bytes[3:0] = `TG_CRC_WORD;
        end
    end

    assign rx_data = beat;

endmodule

`default_nettype wire

//--- traffic_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "tg_macros.svh"

module traffic_gen_top (
    input  wire logic                     axi_aclk,
    input  wire logic                     aresetn,
    input  wire logic [31:0]              timestamp,
    input  wire logic                     rx_ready,
    output logic                          rx_valid,
    output logic [`TG_BEAT_BITS-1:0]      rx_data,
    output logic                          rx_last,
    input  wire logic                     crdt_valid,
    input  wire logic                     qid_fifo_full,
    input  tg_pkg::flow_cfg_t             flow_cfg [`TG_NUM_FLOWS],
    input  wire logic [`TG_NUM_FLOWS-1:0] flow_running,
    output tg_pkg::flow_idx_t             curr_flow_idx
);

    // scheduler handshake
    logic              advance;
    tg_pkg::flow_idx_t cur_idx;

    // engine to composer beat control
    beat_ctrl_if ctrl_if ();

    flow_scheduler sched_i (
        .axi_aclk     (axi_aclk),
        .aresetn      (aresetn),
        .flow_running (flow_running),
        .advance      (advance),
        .cur_idx      (cur_idx)
    );

    flow_engine engine_i (
        .axi_aclk      (axi_aclk),
        .aresetn       (aresetn),
        .flow_cfg      (flow_cfg),
        .flow_running  (flow_running),
        .cur_idx       (cur_idx),
        .rx_ready      (rx_ready),
        .crdt_valid    (crdt_valid),
        .qid_fifo_full (qid_fifo_full),
        .rx_valid      (rx_valid),
        .rx_last       (rx_last),
        .advance       (advance),
        .ctrl          (ctrl_if.source)
    );

    // beat data straight out, no register stage
    beat_composer composer_i (
        .timestamp (timestamp),
        .ctrl      (ctrl_if.sink),
        .rx_data   (rx_data)
    );

    assign curr_flow_idx = cur_idx;

endmodule

`default_nettype wire

//--- tb_traffic_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "tg_macros.svh"

module tb_traffic_gen;

    // longest test is gating at ~200 cycles, whole run well under 600
    localparam int TIMEOUT_CYCLES = 5000;

    logic                       axi_aclk;
    logic                       aresetn;
    logic [31:0]                timestamp;
    logic                       rx_ready;
    logic                       rx_valid;
    logic [`TG_BEAT_BITS-1:0]   rx_data;
    logic                       rx_last;
    logic                       crdt_valid;
    logic                       qid_fifo_full;
    tg_pkg::flow_cfg_t          flow_cfg [`TG_NUM_FLOWS];
    logic [`TG_NUM_FLOWS-1:0]   flow_running;
    tg_pkg::flow_idx_t          curr_flow_idx;

    // accepted beats, in order
    logic [`TG_BEAT_BITS-1:0]   beat_q [$];
    bit                         last_q [$];
    tg_pkg::flow_idx_t          idx_q [$];
    logic [31:0]                ts_q [$];
    int                         cyc_q [$];

    int                         pkt_cnt;
    int                         cycle_cnt;
    int                         fail_cnt;
    bit                         stall_en;
    bit                         stalled;
    logic [`TG_BEAT_BITS-1:0]   held_data;
    logic                       held_last;

    traffic_gen_top dut_i (
        .axi_aclk      (axi_aclk),
        .aresetn       (aresetn),
        .timestamp     (timestamp),
        .rx_ready      (rx_ready),
        .rx_valid      (rx_valid),
        .rx_data       (rx_data),
        .rx_last       (rx_last),
        .crdt_valid    (crdt_valid),
        .qid_fifo_full (qid_fifo_full),
        .flow_cfg      (flow_cfg),
        .flow_running  (flow_running),
        .curr_flow_idx (curr_flow_idx)
    );

    always #5 axi_aclk = ~axi_aclk;

    task automatic check_eq(input logic [511:0] got, input logic [511:0] exp, input string what);
        if (got !== exp) begin
            fail_cnt++;
            $display("MISMATCH at %0t: %s, got %0h expected %0h", $time, what, got, exp);
            $display("Testbench failed");
            $fatal(1, "check failed");
        end
    endtask

    // reference beat straight from the header layout rules
    function automatic logic [511:0] expected_beat(input tg_pkg::flow_cfg_t cfg, input bit first,
                                                   input bit last, input logic [31:0] ts);
        tg_pkg::beat_u     b;
        tg_pkg::hdr_beat_t h;
        for (int k = 0; k < `TG_BEAT_BYTES; k++) begin
            b.bytes[k] = `TG_FILL_BYTE;
        end
        if (first) begin
            h.eth   = {`TG_DST_MAC, cfg.src_mac, `TG_ETHERTYPE};
            h.ip    = {72'h0, `TG_PROTOCOL, 16'h0, cfg.src_ip, `TG_DST_IP};
            h.trans = {cfg.src_port, `TG_DST_PORT, 128'h0};
            h.tail  = {ts, `TG_TAIL_MARK, 32'h0};
            b.hdr   = h;
        end
        // crc lands on the low four bytes
        if (last) begin
            b.bytes[3:0] = `TG_CRC_WORD;
        end
        return b;
    endfunction

    // random stalls only when a test asks for them
    always @(posedge axi_aclk) begin
        rx_ready <= stall_en ? (($urandom % 4) != 0) : 1'b1;
    end

    always @(posedge axi_aclk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1, "timeout");
        end
    end

    // monitor at negedge, where outputs are settled
    always @(negedge axi_aclk) begin
        if (!aresetn) begin
            stalled = 1'b0;
        end else begin
            if (stalled) begin
                check_eq(rx_valid, 1'b1, "rx_valid dropped while stalled");
                check_eq(rx_data, held_data, "rx_data moved while stalled");
                check_eq(rx_last, held_last, "rx_last moved while stalled");
            end
            stalled   = rx_valid && !rx_ready;
            held_data = rx_data;
            held_last = rx_last;
            if (rx_valid && rx_ready) begin
                beat_q.push_back(rx_data);
                last_q.push_back(rx_last);
                idx_q.push_back(curr_flow_idx);
                ts_q.push_back(timestamp);
                cyc_q.push_back(cycle_cnt);
                if (rx_last) begin
                    pkt_cnt++;
                end
            end
        end
    end

    // reset with idle outputs checked during and just after
    task automatic apply_reset;
        @(posedge axi_aclk);
        aresetn       <= 1'b0;
        flow_running  <= '0;
        crdt_valid    <= 1'b1;
        qid_fifo_full <= 1'b0;
        stall_en = 1'b0;
        for (int i = 0; i < 9; i++) begin
            // eight edges see reset low, the ninth is the first one out
            @(posedge axi_aclk);
            if (i == 7) begin
                aresetn <= 1'b1;
            end
            @(negedge axi_aclk);
            check_eq(rx_valid, 1'b0, "rx_valid in reset");
            check_eq(rx_last, 1'b0, "rx_last in reset");
            check_eq(curr_flow_idx, 2'd0, "curr_flow_idx in reset");
        end
        beat_q.delete();
        last_q.delete();
        idx_q.delete();
        ts_q.delete();
        cyc_q.delete();
        pkt_cnt = 0;
    endtask

    task automatic set_flow(input int idx, input logic [31:0] ip, input logic [15:0] size,
                            input logic [31:0] gap);
        flow_cfg[idx] <= {48'h02AB_CD00_0000 + 48'(idx), ip, 16'h5000 + 16'(idx), size, gap};
    endtask

    task automatic wait_packets(input int n);
        while (pkt_cnt < n) begin
            @(negedge axi_aclk);
        end
    endtask

    // pops one packet and compares every beat
    task automatic expect_packet(input int fidx, output int first_cyc);
        int nbeats;
        nbeats = (int'(flow_cfg[fidx].pkt_size) + `TG_BEAT_BYTES - 1) / `TG_BEAT_BYTES;
        first_cyc = cyc_q[0];
        for (int b = 0; b < nbeats; b++) begin
            check_eq(beat_q.pop_front(), expected_beat(flow_cfg[fidx], b == 0,
                     b == nbeats - 1, ts_q.pop_front()), $sformatf("beat %0d data", b));
            check_eq(last_q.pop_front(), b == nbeats - 1, $sformatf("beat %0d rx_last", b));
            check_eq(idx_q.pop_front(), fidx, "curr_flow_idx during packet");
            void'(cyc_q.pop_front());
        end
    endtask

    task automatic single_packet;
        int c;
        apply_reset();
        @(posedge axi_aclk);
        set_flow(0, 32'h0A00_0001, 16'd200, 32'd1000);
        timestamp    <= $urandom;
        flow_running <= 4'b0001;
        wait_packets(1);
        expect_packet(0, c);
        // long pacing gap, nothing more may come out for a while
        repeat (20) @(negedge axi_aclk);
        check_eq(beat_q.size(), 0, "beats beyond the 4-beat packet");
    endtask

    task automatic back_pressure;
        int c;
        apply_reset();
        @(posedge axi_aclk);
        set_flow(1, 32'h0A00_0101, 16'd200, 32'd1);
        timestamp    <= $urandom;
        flow_running <= 4'b0010;
        stall_en = 1'b1;
        wait_packets(2);
        expect_packet(1, c);
        expect_packet(1, c);
        stall_en = 1'b0;
    endtask

    // flows 0 and 2 take turns, flow 2 is a one-beat packet
    task automatic round_robin;
        int c;
        apply_reset();
        @(posedge axi_aclk);
        set_flow(0, 32'h0A00_0011, 16'd100, 32'd1);
        set_flow(2, 32'h0A00_0022, 16'd64, 32'd1);
        timestamp    <= $urandom;
        flow_running <= 4'b0101;
        wait_packets(4);
        for (int p = 0; p < 4; p++) begin
            expect_packet((p % 2) * 2, c);
        end
    endtask

    task automatic start_gating;
        int c;
        apply_reset();
        @(posedge axi_aclk);
        set_flow(3, 32'h0A00_0303, 16'd130, 32'd1);
        crdt_valid   <= 1'b0;
        flow_running <= 4'b1000;
        repeat (50) @(negedge axi_aclk);
        check_eq(beat_q.size(), 0, "start without credit");
        @(posedge axi_aclk);
        crdt_valid    <= 1'b1;
        qid_fifo_full <= 1'b1;
        repeat (50) @(negedge axi_aclk);
        check_eq(beat_q.size(), 0, "start with qid fifo full");
        @(posedge axi_aclk);
        qid_fifo_full <= 1'b0;
        while (!rx_valid) begin
            @(negedge axi_aclk);
        end
        // gate drops under the first beat, packet still has to finish
        @(posedge axi_aclk);
        crdt_valid    <= 1'b0;
        qid_fifo_full <= 1'b1;
        wait_packets(1);
        expect_packet(3, c);
        repeat (50) @(negedge axi_aclk);
        check_eq(beat_q.size(), 0, "restart with gate closed");
    endtask

    task automatic pacing_gap;
        int c0;
        int c1;
        int c2;
        apply_reset();
        @(posedge axi_aclk);
        set_flow(0, 32'h0A00_0044, 16'd128, 32'd40);
        flow_running <= 4'b0001;
        wait_packets(3);
        expect_packet(0, c0);
        expect_packet(0, c1);
        expect_packet(0, c2);
        check_eq(c1 - c0 >= 40 && c1 - c0 <= 43, 1'b1, $sformatf("first gap %0d", c1 - c0));
        check_eq(c2 - c1 >= 40 && c2 - c1 <= 43, 1'b1, $sformatf("second gap %0d", c2 - c1));
    endtask

    initial begin
        void'($urandom(32'h352003db));
        axi_aclk      = 1'b0;
        aresetn       = 1'b0;
        timestamp     = '0;
        rx_ready      = 1'b0;
        crdt_valid    = 1'b1;
        qid_fifo_full = 1'b0;
        flow_running  = '0;
        for (int i = 0; i < `TG_NUM_FLOWS; i++) begin
            flow_cfg[i] = '0;
        end
        single_packet();
        back_pressure();
        round_robin();
        start_gating();
        pacing_gap();
        if (fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
tg_pkg.sv
beat_ctrl_if.sv
flow_scheduler.sv
flow_engine.sv
beat_composer.sv
traffic_gen_top.sv
tb_traffic_gen.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_traffic_gen -f sim.f

out=$(./obj_dir/Vtb_traffic_gen || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Testbench passed"; then
    exit 0
else
    exit 1
fi
